// ==== capture_pkg.sv ====
`default_nettype none

package capture_pkg;

    localparam int RAM_DEPTH  = 256;
    localparam int BANK_COUNT = 4;
    localparam int BANK_DEPTH = 64;
    localparam int ADDR_W     = 8;
    localparam int BANK_SEL_W = 2;  // upper bits of the word address

    typedef struct packed {
        logic [7:0] q_byte;
        logic [7:0] i_byte;
    } iq_sample_t;

    // filled as an i/q pair, drained as two serial bytes
    typedef union packed {
        iq_sample_t      sample;
        logic [1:0][7:0] lanes;  // lane 0 is the in-phase byte
    } capture_word_u;

endpackage

`default_nettype wire

// ==== host_pkg.sv ====
`default_nettype none

package host_pkg;

    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_LENGTH = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_DECIM  = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'hC;

    localparam int LEN_W   = 9;  // 1 to 256 words
    localparam int DECIM_W = 8;

    localparam int CLKS_PER_BIT = 8;

endpackage

`default_nettype wire

// ==== iq_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_sampler (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          capture_en,
    input  wire logic [host_pkg::DECIM_W-1:0]  cfg_decim,
    input  wire logic                          bit_valid,
    input  wire logic                          bit_i,
    input  wire logic                          bit_q,
    output logic                               word_valid,
    output capture_pkg::capture_word_u         word
);
    import host_pkg::*;

    logic [DECIM_W-1:0] skip_cnt;
    logic [2:0]         bit_cnt;
    logic               keep;

    assign keep = bit_valid && (skip_cnt == '0);  // first pulse, then every decim+1

    always_ff @(posedge clk) begin
        word_valid <= 1'b0;
        if (rst || !capture_en) begin
            skip_cnt <= '0;
            bit_cnt  <= '0;
            word     <= '0;  // drop any partial byte
        end else if (bit_valid) begin
            skip_cnt <= (skip_cnt == cfg_decim) ? '0 : skip_cnt + 1'b1;
            if (keep) begin
                word.sample.i_byte <= {word.sample.i_byte[6:0], bit_i};  // msb first
                word.sample.q_byte <= {word.sample.q_byte[6:0], bit_q};
                bit_cnt            <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) begin
                    word_valid <= 1'b1;
                end
            end
        end
    end

    // the sequencer must still be capturing when a word comes out
    a_valid_in_capture: assert property (@(posedge clk) disable iff (rst)
        word_valid |-> capture_en);

endmodule

`default_nettype wire

// ==== capture_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_ram (
    input  wire logic                           clk,
    input  wire logic                           we,
    input  wire logic [capture_pkg::ADDR_W-1:0] addr,
    input  wire capture_pkg::capture_word_u     wdata,
    output capture_pkg::capture_word_u          rdata
);
    import capture_pkg::*;

    localparam int ROW_W = ADDR_W - BANK_SEL_W;

    capture_word_u           mem [BANK_COUNT][BANK_DEPTH];
    capture_word_u           bank_q [BANK_COUNT];
    logic [BANK_SEL_W-1:0]   bank_sel;
    logic [BANK_SEL_W-1:0]   sel_q;
    logic [ROW_W-1:0]        row;

    assign bank_sel = addr[ADDR_W-1 -: BANK_SEL_W];
    assign row      = addr[ROW_W-1:0];

    always_ff @(posedge clk) begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            if (we && (bank_sel == BANK_SEL_W'(b))) begin
                mem[b][row] <= wdata;
            end
            bank_q[b] <= mem[b][row];  // every bank reads the same row
        end
        sel_q <= bank_sel;
    end

    assign rdata = bank_q[sel_q];  // output mux follows the registered bank

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = host_pkg::CLKS_PER_BIT
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       tx_start,
    input  wire logic [7:0] tx_data,
    output logic            serial_out,
    output logic            tx_busy
);
    localparam int CNT_W = $clog2(clks_per_bit + 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;  // 0 start, 1-8 data, 9 stop
    logic [9:0]       frame;

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, tx_data, 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy    <= 1'b0;
            serial_out <= 1'b1;
            clk_cnt    <= '0;
            bit_idx    <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy    <= 1'b1;
                serial_out <= 1'b0;  // start bit
                clk_cnt    <= '0;
                bit_idx    <= '0;
            end
        end else if (clk_cnt == CNT_W'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                tx_busy    <= 1'b0;
                serial_out <= 1'b1;
            end else begin
                bit_idx    <= bit_idx + 1'b1;
                serial_out <= frame[bit_idx + 4'd1];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // the sequencer has to wait for a free line
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        tx_busy |-> !tx_start);

endmodule

`default_nettype wire

// ==== csr_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_axil (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              awvalid,
    input  wire logic [host_pkg::AXI_ADDR_W-1:0]   awaddr,
    output logic                                   awready,
    input  wire logic                              wvalid,
    input  wire logic [host_pkg::AXI_DATA_W-1:0]   wdata,
    input  wire logic [host_pkg::AXI_DATA_W/8-1:0] wstrb,
    output logic                                   wready,
    output logic                                   bvalid,
    output logic [1:0]                             bresp,
    input  wire logic                              bready,
    input  wire logic                              arvalid,
    input  wire logic [host_pkg::AXI_ADDR_W-1:0]   araddr,
    output logic                                   arready,
    output logic                                   rvalid,
    output logic [host_pkg::AXI_DATA_W-1:0]        rdata,
    output logic [1:0]                             rresp,
    input  wire logic                              rready,
    output logic                                   start,
    output logic [host_pkg::LEN_W-1:0]             cfg_length,
    output logic [host_pkg::DECIM_W-1:0]           cfg_decim,
    input  wire logic                              capturing,
    input  wire logic                              dumping,
    input  wire logic                              done
);
    import host_pkg::*;
    import capture_pkg::*;

    logic                    aw_full;
    logic                    w_full;
    logic                    start_req;
    logic                    do_write;
    logic [AXI_ADDR_W-1:0]   aw_addr_q;
    logic [AXI_DATA_W-1:0]   w_data_q;
    logic [AXI_DATA_W/8-1:0] w_strb_q;
    logic [AXI_DATA_W-1:0]   old_val;
    logic [AXI_DATA_W-1:0]   merged;
    logic [AXI_DATA_W-1:0]   rd_mux;
    logic [LEN_W-1:0]        len_clamped;

    assign do_write = aw_full && w_full;
    assign bresp    = 2'b00;
    assign rresp    = 2'b00;

    always_comb begin
        case (aw_addr_q)
            REG_LENGTH: old_val = AXI_DATA_W'(cfg_length);
            REG_DECIM:  old_val = AXI_DATA_W'(cfg_decim);
            default:    old_val = '0;
        endcase
        for (int k = 0; k < AXI_DATA_W / 8; k++) begin
            merged[k*8 +: 8] = w_strb_q[k] ? w_data_q[k*8 +: 8] : old_val[k*8 +: 8];
        end
        if (merged == '0) begin
            len_clamped = LEN_W'(1);
        end else if (merged > AXI_DATA_W'(RAM_DEPTH)) begin
            len_clamped = LEN_W'(RAM_DEPTH);
        end else begin
            len_clamped = merged[LEN_W-1:0];
        end
        case (araddr)
            REG_CTRL:   rd_mux = '0;
            REG_LENGTH: rd_mux = AXI_DATA_W'(cfg_length);
            REG_DECIM:  rd_mux = AXI_DATA_W'(cfg_decim);
            REG_STATUS: rd_mux = AXI_DATA_W'({done, dumping, capturing});
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            start_req  <= 1'b0;
            start      <= 1'b0;
            cfg_length <= LEN_W'(1);
            cfg_decim  <= '0;
        end else begin
            start <= 1'b0;
            // address and data beats fill independently
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_full <= 1'b1;
            end else if (!aw_full && !bvalid) begin
                awready <= 1'b1;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_full <= 1'b1;
            end else if (!w_full && !bvalid) begin
                wready <= 1'b1;
            end
            if (do_write) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                bvalid  <= 1'b1;
                case (aw_addr_q)
                    REG_CTRL:   start_req  <= merged[0];
                    REG_LENGTH: cfg_length <= len_clamped;
                    REG_DECIM:  cfg_decim  <= merged[DECIM_W-1:0];
                    default:    ;
                endcase
            end
            if (bvalid && bready) begin
                bvalid    <= 1'b0;
                start_req <= 1'b0;
                start     <= start_req && !capturing && !dumping;  // dropped while busy
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                rdata   <= rd_mux;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (!rvalid) begin
                arready <= 1'b1;
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// ==== dump_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire logic [host_pkg::LEN_W-1:0]    cfg_length,
    input  wire logic [host_pkg::DECIM_W-1:0]  cfg_decim,
    output logic                               capture_en,
    output logic [host_pkg::DECIM_W-1:0]       sampler_decim,
    input  wire logic                          word_valid,
    input  wire capture_pkg::capture_word_u    word,
    output logic                               ram_we,
    output logic [capture_pkg::ADDR_W-1:0]     ram_addr,
    output capture_pkg::capture_word_u         ram_wdata,
    input  wire capture_pkg::capture_word_u    ram_rdata,
    output logic                               tx_start,
    output logic [7:0]                         tx_data,
    input  wire logic                          tx_busy,
    output logic                               capturing,
    output logic                               dumping,
    output logic                               done
);
    import host_pkg::*;
    import capture_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        DUMP_FETCH,
        DUMP_LOW,
        DUMP_HIGH,
        FINISH
    } state_t;

    state_t            state;
    logic [LEN_W-1:0]  len_q;
    logic [ADDR_W-1:0] addr_q;
    logic              last_word;
    logic              tx_free;

    assign last_word  = (LEN_W'(addr_q) == len_q - 1'b1);
    assign tx_free    = !tx_busy && !tx_start;  // busy lags start by a clock
    assign capture_en = (state == CAPTURE);
    assign capturing  = capture_en;
    assign dumping    = state inside {DUMP_FETCH, DUMP_LOW, DUMP_HIGH, FINISH};
    assign ram_we     = capture_en && word_valid;
    assign ram_addr   = addr_q;
    assign ram_wdata  = word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            addr_q   <= '0;
            tx_start <= 1'b0;
            done     <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state  <= CAPTURE;
                    addr_q <= '0;
                    done   <= 1'b0;
                end
                CAPTURE: if (word_valid) begin
                    addr_q <= last_word ? '0 : addr_q + 1'b1;
                    if (last_word) begin
                        state <= DUMP_FETCH;
                    end
                end
                DUMP_FETCH: state <= DUMP_LOW;  // ram read latency
                DUMP_LOW: if (tx_free) begin
                    tx_start <= 1'b1;
                    state    <= DUMP_HIGH;
                end
                DUMP_HIGH: if (tx_free) begin
                    tx_start <= 1'b1;
                    addr_q   <= addr_q + 1'b1;
                    state    <= last_word ? FINISH : DUMP_FETCH;
                end
                FINISH: if (tx_free) begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            len_q         <= cfg_length;
            sampler_decim <= cfg_decim;
        end
        if (state == DUMP_LOW && tx_free) begin
            tx_data <= ram_rdata.lanes[0];  // in-phase byte first
        end
        if (state == DUMP_HIGH && tx_free) begin
            tx_data <= ram_rdata.lanes[1];
        end
    end

    // a write either continues capture or ends it straight into the dump
    a_we_in_capture: assert property (@(posedge clk) disable iff (rst)
        ram_we |=> state inside {CAPTURE, DUMP_FETCH});

endmodule

`default_nettype wire

// ==== capture_dump_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_dump_top (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              awvalid,
    input  wire logic [host_pkg::AXI_ADDR_W-1:0]   awaddr,
    output logic                                   awready,
    input  wire logic                              wvalid,
    input  wire logic [host_pkg::AXI_DATA_W-1:0]   wdata,
    input  wire logic [host_pkg::AXI_DATA_W/8-1:0] wstrb,
    output logic                                   wready,
    output logic                                   bvalid,
    output logic [1:0]                             bresp,
    input  wire logic                              bready,
    input  wire logic                              arvalid,
    input  wire logic [host_pkg::AXI_ADDR_W-1:0]   araddr,
    output logic                                   arready,
    output logic                                   rvalid,
    output logic [host_pkg::AXI_DATA_W-1:0]        rdata,
    output logic [1:0]                             rresp,
    input  wire logic                              rready,
    input  wire logic                              bit_valid,
    input  wire logic                              bit_i,
    input  wire logic                              bit_q,
    output logic                                   serial_out
);
    wire logic                            start;
    wire logic                            capturing;
    wire logic                            dumping;
    wire logic                            done;
    wire logic [host_pkg::LEN_W-1:0]      cfg_length;
    wire logic [host_pkg::DECIM_W-1:0]    cfg_decim;
    wire logic [host_pkg::DECIM_W-1:0]    sampler_decim;
    wire logic                            capture_en;
    wire logic                            word_valid;
    wire capture_pkg::capture_word_u      word;
    wire logic                            ram_we;
    wire logic [capture_pkg::ADDR_W-1:0]  ram_addr;
    wire capture_pkg::capture_word_u      ram_wdata;
    wire capture_pkg::capture_word_u      ram_rdata;
    wire logic                            tx_start;
    wire logic [7:0]                      tx_data;
    wire logic                            tx_busy;

    csr_axil csr_axil_inst (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .start(start), .cfg_length(cfg_length), .cfg_decim(cfg_decim),
        .capturing(capturing), .dumping(dumping), .done(done)
    );

    dump_sequencer dump_sequencer_inst (
        .clk(clk), .rst(rst),
        .start(start), .cfg_length(cfg_length), .cfg_decim(cfg_decim),
        .capture_en(capture_en), .sampler_decim(sampler_decim),
        .word_valid(word_valid), .word(word),
        .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata),
        .tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy),
        .capturing(capturing), .dumping(dumping), .done(done)
    );

    iq_sampler iq_sampler_inst (
        .clk(clk), .rst(rst),
        .capture_en(capture_en), .cfg_decim(sampler_decim),
        .bit_valid(bit_valid), .bit_i(bit_i), .bit_q(bit_q),
        .word_valid(word_valid), .word(word)
    );

    capture_ram capture_ram_inst (
        .clk(clk), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    uart_tx uart_tx_inst (
        .clk(clk), .rst(rst),
        .tx_start(tx_start), .tx_data(tx_data),
        .serial_out(serial_out), .tx_busy(tx_busy)
    );

endmodule

`default_nettype wire

// ==== tb_capture_dump.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_capture_dump;
    import host_pkg::*;

    logic                    clk;
    logic                    rst;
    logic                    awvalid;
    logic [AXI_ADDR_W-1:0]   awaddr;
    logic                    awready;
    logic                    wvalid;
    logic [AXI_DATA_W-1:0]   wdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    wready;
    logic                    bvalid;
    logic [1:0]              bresp;
    logic                    bready;
    logic                    arvalid;
    logic [AXI_ADDR_W-1:0]   araddr;
    logic                    arready;
    logic                    rvalid;
    logic [AXI_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rready;
    logic                    bit_valid;
    logic                    bit_i;
    logic                    bit_q;
    logic                    serial_out;

    integer     seed;
    int         errors;
    int         test_errors;
    int         tests_run;
    int         tests_failed;
    int         checks;
    int         limit_cycles;
    logic [7:0] rx_q[$];  // bytes seen on the serial line

    capture_dump_top capture_dump_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % 32'(hi - lo + 1));
    endfunction

    // capture time at worst 4 clocks per pulse, dump time 10 bits per byte
    function automatic int run_budget(input int words, input int decim);
        return 2 * words * 10 * CLKS_PER_BIT + words * 8 * (decim + 1) * 4 + 2000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data);
        int w_delay;
        int cnt;
        bit aw_done;
        bit w_done;
        w_delay = rand_range(0, 3);  // data beat may trail the address
        cnt     = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awvalid <= 1'b1;
        awaddr  <= addr;
        while (!(aw_done && w_done)) begin
            if (cnt == w_delay) begin
                wvalid <= 1'b1;
                wdata  <= data;
                wstrb  <= '1;
            end
            @(posedge clk);
            if (!aw_done && awready) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (cnt >= w_delay && !w_done && wready) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
            cnt++;
        end
        repeat (rand_range(0, 3)) @(posedge clk);
        bready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!bvalid);
        bready <= 1'b0;
        check_value("bresp", 32'(bresp), 32'd0);
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
                            output logic [AXI_DATA_W-1:0] data);
        arvalid <= 1'b1;
        araddr  <= addr;
        do begin
            @(posedge clk);
        end while (!arready);
        arvalid <= 1'b0;
        repeat (rand_range(0, 3)) @(posedge clk);
        rready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rvalid);
        data = rdata;
        rready <= 1'b0;
        check_value("rresp", 32'(rresp), 32'd0);
    endtask

    task automatic wait_status(input logic [AXI_DATA_W-1:0] mask);
        logic [AXI_DATA_W-1:0] v;
        v = '0;
        while ((v & mask) == '0) begin
            axi_read(REG_STATUS, v);
        end
    endtask

    task automatic run_capture(input string name, input int words, input int decim,
                               input bit restart);
        logic [7:0]            i_acc;
        logic [7:0]            q_acc;
        logic                  bi;
        logic                  bq;
        logic [AXI_DATA_W-1:0] status;
        logic [7:0]            exp_q[$];
        int                    pulse;
        int                    kept;
        int                    n;
        i_acc = '0;
        q_acc = '0;
        pulse = 0;
        kept  = 0;
        rx_q.delete();
        axi_write(REG_LENGTH, AXI_DATA_W'(words));
        axi_write(REG_DECIM, AXI_DATA_W'(decim));
        axi_write(REG_CTRL, 32'd1);
        wait_status(32'h1);
        while (kept < words * 8) begin
            bi = 1'($random(seed));
            bq = 1'($random(seed));
            bit_valid <= 1'b1;
            bit_i     <= bi;
            bit_q     <= bq;
            if (pulse % (decim + 1) == 0) begin  // kept pulse
                i_acc = {i_acc[6:0], bi};
                q_acc = {q_acc[6:0], bq};
                kept++;
                if (kept % 8 == 0) begin
                    exp_q.push_back(i_acc);  // in-phase byte goes out first
                    exp_q.push_back(q_acc);
                end
            end
            pulse++;
            @(posedge clk);
            bit_valid <= 1'b0;
            repeat (rand_range(1, 3)) @(posedge clk);
        end
        if (restart) begin
            wait_status(32'h2);
            axi_write(REG_CTRL, 32'd1);  // lands mid-dump
        end
        wait_status(32'h4);
        axi_read(REG_STATUS, status);
        check_value({name, " status"}, status, 32'h4);
        check_value({name, " byte count"}, 32'(rx_q.size()), 32'(exp_q.size()));
        for (n = 0; n < exp_q.size() && n < rx_q.size(); n++) begin
            check_value($sformatf("%s byte %0d", name, n), 32'(rx_q[n]), 32'(exp_q[n]));
        end
    endtask

    initial begin : uart_decoder
        logic [7:0] rx_byte;
        int         b;
        rx_byte = '0;
        forever begin
            @(posedge clk);
            if (!rst && serial_out === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(posedge clk);
                if (serial_out !== 1'b0) begin
                    $display("uart decoder: start bit did not stay low");
                    errors++;
                    test_errors++;
                end
                for (b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    rx_byte = {serial_out, rx_byte[7:1]};  // lsb arrives first
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                if (serial_out !== 1'b1) begin
                    $display("uart decoder: stop bit was low after byte 0x%0h", rx_byte);
                    errors++;
                    test_errors++;
                end
                rx_q.push_back(rx_byte);
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d clock cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [AXI_DATA_W-1:0] v;
        logic [AXI_DATA_W-1:0] wval;
        int                    len2;
        int                    len3;
        int                    decim3;
        int                    len4;
        seed         = 32'h72bfa34e;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        limit_cycles = 0;
        rst       = 1'b1;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        bit_valid = 1'b0;
        bit_i     = 1'b0;
        bit_q     = 1'b0;
        len2   = rand_range(1, 32);
        len3   = rand_range(1, 32);
        decim3 = rand_range(1, 7);
        len4   = rand_range(1, 32);
        limit_cycles = 2 * (run_budget(len2, 0) + run_budget(len3, decim3)
                       + run_budget(len4, 0) + run_budget(256, 0) + 2000);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        axi_read(REG_STATUS, v);
        check_value("reset status", v, 32'h0);
        axi_read(REG_LENGTH, v);
        check_value("reset length", v, 32'h1);
        axi_read(REG_DECIM, v);
        check_value("reset decim", v, 32'h0);
        wval = AXI_DATA_W'(rand_range(1, 256));
        axi_write(REG_LENGTH, wval);
        axi_read(REG_LENGTH, v);
        check_value("length readback", v, wval);
        axi_write(REG_LENGTH, 32'h0);
        axi_read(REG_LENGTH, v);
        check_value("length clamp low", v, 32'h1);
        wval = 32'($random(seed)) | 32'h200;  // always above 256
        axi_write(REG_LENGTH, wval);
        axi_read(REG_LENGTH, v);
        check_value("length clamp high", v, 32'd256);
        wval = AXI_DATA_W'(rand_range(0, 255));
        axi_write(REG_DECIM, wval);
        axi_read(REG_DECIM, v);
        check_value("decim readback", v, wval);
        axi_read(4'h6, v);
        check_value("unmapped read", v, 32'h0);
        finish_test("reg_basics");

        run_capture("decim0", len2, 0, 1'b0);
        finish_test("decim0");
        run_capture("decim_rand", len3, decim3, 1'b0);
        finish_test("decim_rand");
        run_capture("start_busy", len4, 0, 1'b1);
        finish_test("start_busy");
        run_capture("full_depth", 256, 0, 1'b0);
        finish_test("full_depth");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
capture_pkg.sv
host_pkg.sv
iq_sampler.sv
capture_ram.sv
uart_tx.sv
csr_axil.sv
dump_sequencer.sv
capture_dump_top.sv
tb_capture_dump.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_capture_dump \
    -f sources.f -o tb_capture_dump

out=$(./obj_dir/tb_capture_dump 2>&1 || true)
printf '%s\n' "$out"

# the run passes only when the testbench printed its pass line
printf '%s\n' "$out" | grep -q "SIMULATION PASSED"
